/* verilog/datapath_config.svh */
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

`define NUMFLAGS 51

// DB sources
`define DB_FROM_PSR 0
`define DB_FROM_PCH 1
`define DB_FROM_PCL 2
`define DB_FROM_ACC 3
`define DB_FROM_DATA 4

// ADL and ADH sources
`define ADL_FROM_SP 5
`define ADL_FROM_ALU 6
`define ADL_FROM_PCL 7
`define ADL_FROM_DATA 8
`define ADH_FROM_PCH 9
`define ADH_FROM_DATA 10

// SB sources
`define SB_FROM_X 11
`define SB_FROM_Y 12
`define SB_FROM_SP 13
`define SB_FROM_ALU 14
`define SB_FROM_ACC 15

`define ADL_PRESET_LSB 16 // 3 bits, FA..FF then 00
`define ADH_PRESET_LSB 19 // 2 bits, 00 01 FF

`define BRIDGE_SB_DB 21
`define BRIDGE_SB_ADH 22

// Register loads
`define LOAD_X 23
`define LOAD_Y 24
`define LOAD_ACC 25
`define LOAD_SP 26
`define LOAD_ABL 27
`define LOAD_ABH 28
`define LOAD_DOR 29
`define LOAD_ALU 30
`define PC_INC 31
`define LOAD_PC 32

// ALU control
`define ALU_OP_LSB 33 // 3 bits
`define ALU_A_ZERO 36
`define ALU_B_LSB 37 // 2 bits, DB / ~DB / ADL / 00
`define CARRY_HIGH 39
`define CARRY_FROM_PSR 40

// Status register control
`define PSR_FROM_DB 41
`define Z_FROM_DB 42
`define N_FROM_DB 43
`define C_FROM_ALU 44
`define V_FROM_ALU 45
`define SET_C 46
`define SET_I 47
`define SET_D 48
`define MANUAL_VALUE 49
`define BREAK_READ 50

`endif

/* verilog/dataTypesPkg.sv */
`include "datapath_config.svh"

package dataTypesPkg;

    // One byte on any internal bus or in any register
    typedef logic [7:0] byteT;

    // Full program counter, PCH:PCL
    typedef logic [15:0] pcT;

    // Control word from the outside controller, one per cycle
    typedef logic [`NUMFLAGS-1:0] flagsT;

endpackage

/* verilog/aluStatusPkg.sv */
package aluStatusPkg;

    typedef enum logic [2:0] {
        aluNone = 3'd0,
        aluAdd  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluEor  = 3'd4,
        aluRor  = 3'd5
    } aluOpT;

    // Processor status word, bit 5 always reads 1
    typedef logic [7:0] statusT;

    localparam int STATUS_C = 0;
    localparam int STATUS_Z = 1;
    localparam int STATUS_I = 2;
    localparam int STATUS_D = 3;
    localparam int STATUS_B = 4; // Only on the DB read-out
    localparam int STATUS_V = 6;
    localparam int STATUS_N = 7;

endpackage

/* verilog/internalBus.sv */
`timescale 1ns/10ps

module internalBus
    import dataTypesPkg::*;
#(
    parameter int INPUT_COUNT = 3
) (
    input  logic [INPUT_COUNT*8-1:0] sources,
    input  logic [INPUT_COUNT-1:0]   selects,
    output byteT                     busValue
);

    // Precharged lines, any driving source can only pull bits low
    always_comb begin
        busValue = 8'hFF;
        for (int i = 0; i < INPUT_COUNT; i++) begin
            if (selects[i]) begin
                busValue &= sources[i*8 +: 8];
            end
        end
    end

endmodule

/* verilog/busNetwork.sv */
`timescale 1ns/10ps
`include "datapath_config.svh"

module busNetwork
    import dataTypesPkg::*;
(
    input  flagsT flags,
    input  byteT  externalDBRead,
    input  byteT  x, y, acc, sp,
    input  byteT  pcl, pch,
    input  byteT  aluHold,
    input  byteT  psrToDb,
    output byteT  dataBus,
    output byteT  stackBus,
    output byteT  addressLowBus,
    output byteT  addressHighBus
);

    byteT dbRaw, sbRaw, adhRaw;
    byteT adlPreset, adhPreset;
    byteT sbMerged;
    logic adlPresetSel, adhPresetSel;

    always_comb begin
        case (flags[`ADL_PRESET_LSB +: 3])
            3'd1: adlPreset = 8'hFA;
            3'd2: adlPreset = 8'hFB;
            3'd3: adlPreset = 8'hFC;
            3'd4: adlPreset = 8'hFD;
            3'd5: adlPreset = 8'hFE;
            3'd6: adlPreset = 8'hFF;
            default: adlPreset = 8'h00; // Code 7, code 0 is masked by the select
        endcase
        case (flags[`ADH_PRESET_LSB +: 2])
            2'd1: adhPreset = 8'h00;
            2'd2: adhPreset = 8'h01;
            default: adhPreset = 8'hFF;
        endcase
    end

    assign adlPresetSel = |flags[`ADL_PRESET_LSB +: 3];
    assign adhPresetSel = |flags[`ADH_PRESET_LSB +: 2];

    internalBus #(.INPUT_COUNT(5)) dbBus (
        .sources ({psrToDb, pch, pcl, acc, externalDBRead}),
        .selects ({flags[`DB_FROM_PSR], flags[`DB_FROM_PCH], flags[`DB_FROM_PCL],
                   flags[`DB_FROM_ACC], flags[`DB_FROM_DATA]}),
        .busValue(dbRaw)
    );

    internalBus #(.INPUT_COUNT(5)) sbBus (
        .sources ({x, y, sp, aluHold, acc}),
        .selects ({flags[`SB_FROM_X], flags[`SB_FROM_Y], flags[`SB_FROM_SP],
                   flags[`SB_FROM_ALU], flags[`SB_FROM_ACC]}),
        .busValue(sbRaw)
    );

    internalBus #(.INPUT_COUNT(5)) adlBus (
        .sources ({sp, aluHold, pcl, externalDBRead, adlPreset}),
        .selects ({flags[`ADL_FROM_SP], flags[`ADL_FROM_ALU], flags[`ADL_FROM_PCL],
                   flags[`ADL_FROM_DATA], adlPresetSel}),
        .busValue(addressLowBus)
    );

    internalBus #(.INPUT_COUNT(3)) adhBus (
        .sources ({pch, externalDBRead, adhPreset}),
        .selects ({flags[`ADH_FROM_PCH], flags[`ADH_FROM_DATA], adhPresetSel}),
        .busValue(adhRaw)
    );

    // SB sits between both bridges, so it always sees the full merge
    assign sbMerged = sbRaw & (flags[`BRIDGE_SB_DB] ? dbRaw : 8'hFF)
                            & (flags[`BRIDGE_SB_ADH] ? adhRaw : 8'hFF);

    assign stackBus       = sbMerged;
    assign dataBus        = flags[`BRIDGE_SB_DB] ? sbMerged : dbRaw;
    assign addressHighBus = flags[`BRIDGE_SB_ADH] ? sbMerged : adhRaw;

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/10ps
`include "datapath_config.svh"

module registerFile
    import dataTypesPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  flagsT flags,
    input  byteT  dataBus,
    input  byteT  stackBus,
    input  byteT  addressLowBus,
    input  byteT  addressHighBus,
    output byteT  x, y, acc, sp,
    output byteT  addressLow,
    output byteT  addressHigh,
    output byteT  dataOut
);

    always_ff @(posedge clk) begin
        if (reset) begin
            x           <= '0;
            y           <= '0;
            acc         <= '0;
            sp          <= '0;
            addressLow  <= '0;
            addressHigh <= '0;
            dataOut     <= '0;
        end else begin
            // Index, accumulator and stack pointer all sit on SB
            if (flags[`LOAD_X])   x   <= stackBus;
            if (flags[`LOAD_Y])   y   <= stackBus;
            if (flags[`LOAD_ACC]) acc <= stackBus;
            if (flags[`LOAD_SP])  sp  <= stackBus;

            if (flags[`LOAD_ABL]) addressLow  <= addressLowBus;
            if (flags[`LOAD_ABH]) addressHigh <= addressHighBus;
            if (flags[`LOAD_DOR]) dataOut     <= dataBus; // Write data to the pins
        end
    end

endmodule

/* verilog/programCounter.sv */
`timescale 1ns/10ps
`include "datapath_config.svh"

module programCounter
    import dataTypesPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  flagsT flags,
    input  byteT  addressLowBus,
    input  byteT  addressHighBus,
    output byteT  pcl,
    output byteT  pch,
    output logic  pclMSB
);

    pcT pc, pcBase, pcNext;

    // Jumps take the address bus pair as the new base
    assign pcBase = flags[`LOAD_PC] ? {addressHighBus, addressLowBus} : pc;
    assign pcNext = pcBase + pcT'(flags[`PC_INC]); // PCL carry ripples into PCH

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign pcl    = pc[7:0];
    assign pch    = pc[15:8];
    assign pclMSB = pc[7];

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps
`include "datapath_config.svh"

module alu
    import dataTypesPkg::*, aluStatusPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  flagsT flags,
    input  byteT  dataBus,
    input  byteT  stackBus,
    input  byteT  addressLowBus,
    input  logic  psrCarry,
    output byteT  aluHold,
    output logic  carryOut,
    output logic  overflowOut
);

    aluOpT      op;
    byteT       operandA, operandB, result;
    logic       carryIn;
    logic [8:0] sum;

    assign op       = aluOpT'(flags[`ALU_OP_LSB +: 3]);
    assign operandA = flags[`ALU_A_ZERO] ? 8'h00 : stackBus;
    assign carryIn  = flags[`CARRY_HIGH] | (flags[`CARRY_FROM_PSR] & psrCarry);

    always_comb begin
        case (flags[`ALU_B_LSB +: 2])
            2'd0: operandB = dataBus;
            2'd1: operandB = ~dataBus; // Subtract path with carry high
            2'd2: operandB = addressLowBus;
            default: operandB = 8'h00;
        endcase
    end

    assign sum = {1'b0, operandA} + {1'b0, operandB} + 9'(carryIn);

    always_comb begin
        result      = 8'h00;
        carryOut    = 1'b0;
        overflowOut = 1'b0;
        case (op)
            aluAdd: begin
                result      = sum[7:0];
                carryOut    = sum[8];
                // Signed overflow, like-signed inputs give a different sign
                overflowOut = (operandA[7] == operandB[7]) && (sum[7] != operandA[7]);
            end
            aluAnd: result = operandA & operandB;
            aluOr:  result = operandA | operandB;
            aluEor: result = operandA ^ operandB;
            aluRor: begin
                result   = {carryIn, operandA[7:1]};
                carryOut = operandA[0];
            end
            default: result = 8'h00; // aluNone and unused codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aluHold <= '0;
        end else if (flags[`LOAD_ALU]) begin
            aluHold <= result;
        end
    end

endmodule

/* verilog/statusRegister.sv */
`timescale 1ns/10ps
`include "datapath_config.svh"

module statusRegister
    import dataTypesPkg::*, aluStatusPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  flagsT  flags,
    input  byteT   dataBus,
    input  logic   carryIn,
    input  logic   overflowIn,
    input  logic   setOverflow,
    output statusT status,
    output byteT   psrToDb
);

    statusT statusNext;
    logic   manualValue;

    assign manualValue = flags[`MANUAL_VALUE];

    always_comb begin
        statusNext = status;
        if (flags[`PSR_FROM_DB]) begin
            // Full restore, e.g. a pull of P from the stack
            statusNext[STATUS_C] = dataBus[0];
            statusNext[STATUS_Z] = dataBus[1];
            statusNext[STATUS_I] = dataBus[2];
            statusNext[STATUS_D] = dataBus[3];
            statusNext[STATUS_V] = dataBus[6];
            statusNext[STATUS_N] = dataBus[7];
        end else begin
            if (flags[`Z_FROM_DB]) statusNext[STATUS_Z] = (dataBus == 8'h00);
            if (flags[`N_FROM_DB]) statusNext[STATUS_N] = dataBus[7];
            if (flags[`C_FROM_ALU]) begin
                statusNext[STATUS_C] = carryIn;
            end else if (flags[`SET_C]) begin
                statusNext[STATUS_C] = manualValue;
            end
            if (flags[`V_FROM_ALU]) statusNext[STATUS_V] = overflowIn;
            if (flags[`SET_I]) statusNext[STATUS_I] = manualValue;
            if (flags[`SET_D]) statusNext[STATUS_D] = manualValue;
        end
        if (setOverflow) statusNext[STATUS_V] = 1'b1; // SO pin wins over everything
        statusNext[5]        = 1'b1;
        statusNext[STATUS_B] = 1'b0; // Not stored
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= 8'h24; // I set, bit 5 set
        end else begin
            status <= statusNext;
        end
    end

    always_comb begin
        psrToDb              = status;
        psrToDb[5]           = 1'b1;
        psrToDb[STATUS_B]    = flags[`BREAK_READ]; // Pushed copy marks BRK vs IRQ
    end

endmodule

/* verilog/internalDataflow.sv */
`timescale 1ns/10ps

module internalDataflow
    import dataTypesPkg::*, aluStatusPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  flagsT  flags,
    input  byteT   externalDBRead,
    input  logic   setOverflow,
    output byteT   externalDBWrite,
    output byteT   addressLow,
    output byteT   addressHigh,
    output statusT status,
    output logic   aluCarryOut,
    output logic   pclMSB
);

    byteT dataBus, stackBus, addressLowBus, addressHighBus;
    byteT x, y, acc, sp;
    byteT pcl, pch;
    byteT aluHold, psrToDb;
    logic aluOverflow;

    busNetwork busNetwork_inst (
        .flags(flags), .externalDBRead(externalDBRead),
        .x(x), .y(y), .acc(acc), .sp(sp), .pcl(pcl), .pch(pch),
        .aluHold(aluHold), .psrToDb(psrToDb),
        .dataBus(dataBus), .stackBus(stackBus),
        .addressLowBus(addressLowBus), .addressHighBus(addressHighBus)
    );

    registerFile registerFile_inst (
        .clk(clk), .reset(reset), .flags(flags),
        .dataBus(dataBus), .stackBus(stackBus),
        .addressLowBus(addressLowBus), .addressHighBus(addressHighBus),
        .x(x), .y(y), .acc(acc), .sp(sp),
        .addressLow(addressLow), .addressHigh(addressHigh), .dataOut(externalDBWrite)
    );

    programCounter programCounter_inst (
        .clk(clk), .reset(reset), .flags(flags),
        .addressLowBus(addressLowBus), .addressHighBus(addressHighBus),
        .pcl(pcl), .pch(pch), .pclMSB(pclMSB)
    );

    alu alu_inst (
        .clk(clk), .reset(reset), .flags(flags),
        .dataBus(dataBus), .stackBus(stackBus), .addressLowBus(addressLowBus),
        .psrCarry(status[STATUS_C]),
        .aluHold(aluHold), .carryOut(aluCarryOut), .overflowOut(aluOverflow)
    );

    statusRegister statusRegister_inst (
        .clk(clk), .reset(reset), .flags(flags), .dataBus(dataBus),
        .carryIn(aluCarryOut), .overflowIn(aluOverflow), .setOverflow(setOverflow),
        .status(status), .psrToDb(psrToDb)
    );

endmodule

/* test/tbInternalDataflow.sv */
`timescale 1ns/10ps
`include "datapath_config.svh"

module tbInternalDataflow
    import dataTypesPkg::*, aluStatusPkg::*;
();

    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 40; // Upper bound, the directed part uses about 30
    localparam int RANDOM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50;

    logic   clk;
    logic   reset;
    flagsT  flags;
    byteT   externalDBRead;
    logic   setOverflow;
    byteT   externalDBWrite, addressLow, addressHigh;
    statusT status;
    logic   aluCarryOut, pclMSB;

    // Reference model state
    byteT   mX, mY, mAcc, mSp, mAbl, mAbh, mDor, mHold;
    pcT     mPc;
    statusT mStatus;

    // Model values of the current cycle
    byteT eDb, eSb, eAdl, eAdh, eResult;
    logic eCarry, eOverflow;

    int          byteErrors = 0;
    int          statusErrors = 0;
    int          bitErrors = 0;
    int          clockCount = 0;
    logic [15:0] lfsrState;

    internalDataflow internalDataflow_inst (
        .clk(clk), .reset(reset), .flags(flags), .externalDBRead(externalDBRead),
        .setOverflow(setOverflow), .externalDBWrite(externalDBWrite),
        .addressLow(addressLow), .addressHigh(addressHigh), .status(status),
        .aluCarryOut(aluCarryOut), .pclMSB(pclMSB)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        clockCount <= clockCount + 1;
        if (clockCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run went beyond %0d clock cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic nextRandomBit();
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        return lfsrState[0];
    endfunction

    function automatic logic [63:0] randomBits(int count);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            r[i] = nextRandomBit();
        end
        return r;
    endfunction

    function automatic flagsT flagWord(int b0, int b1 = -1, int b2 = -1, int b3 = -1,
                                       int b4 = -1, int b5 = -1);
        flagsT f;
        int    bits[6];
        f = '0;
        bits = '{b0, b1, b2, b3, b4, b5};
        foreach (bits[i]) begin
            if (bits[i] >= 0) f[bits[i]] = 1'b1;
        end
        return f;
    endfunction

    function automatic flagsT withField(flagsT f, int lsb, int width, int value);
        flagsT r;
        r = f;
        for (int i = 0; i < width; i++) begin
            r[lsb + i] = value[i];
        end
        return r;
    endfunction

    // Vector addresses FA..FF for codes 1..6, code 7 gives 00
    function automatic byteT adlPresetValue(logic [2:0] code);
        return (code == 3'd7) ? 8'h00 : 8'hF9 + byteT'(code);
    endfunction

    function automatic byteT adhPresetValue(logic [1:0] code);
        case (code)
            2'd1: return 8'h00;
            2'd2: return 8'h01;
            default: return 8'hFF;
        endcase
    endfunction

    task automatic compareByte(string name, byteT expected, byteT actual);
        if (actual !== expected) begin
            byteErrors++;
            $display("ERR %0t: %s expected %02h, got %02h", $time, name, expected, actual);
        end
    endtask

    task automatic compareStatus(string name, statusT expected, statusT actual);
        if (actual !== expected) begin
            statusErrors++;
            $display("ERR %0t: %s expected %02h, got %02h", $time, name, expected, actual);
        end
    endtask

    task automatic compareBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            bitErrors++;
            $display("ERR %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic resetModel();
        {mX, mY, mAcc, mSp, mAbl, mAbh, mDor, mHold} = '0;
        mPc = '0;
        mStatus = 8'h24;
    endtask

    task automatic evaluateModel();
        byteT       dbRaw, sbRaw, adhRaw, merged, psrOut, opA, opB;
        logic       cin;
        logic [8:0] total;
        aluOpT      op;
        psrOut = mStatus | 8'h20;
        psrOut[STATUS_B] = flags[`BREAK_READ];
        dbRaw = 8'hFF; // Precharge
        if (flags[`DB_FROM_PSR])  dbRaw &= psrOut;
        if (flags[`DB_FROM_PCH])  dbRaw &= mPc[15:8];
        if (flags[`DB_FROM_PCL])  dbRaw &= mPc[7:0];
        if (flags[`DB_FROM_ACC])  dbRaw &= mAcc;
        if (flags[`DB_FROM_DATA]) dbRaw &= externalDBRead;
        sbRaw = 8'hFF;
        if (flags[`SB_FROM_X])   sbRaw &= mX;
        if (flags[`SB_FROM_Y])   sbRaw &= mY;
        if (flags[`SB_FROM_SP])  sbRaw &= mSp;
        if (flags[`SB_FROM_ALU]) sbRaw &= mHold;
        if (flags[`SB_FROM_ACC]) sbRaw &= mAcc;
        eAdl = 8'hFF;
        if (flags[`ADL_FROM_SP])   eAdl &= mSp;
        if (flags[`ADL_FROM_ALU])  eAdl &= mHold;
        if (flags[`ADL_FROM_PCL])  eAdl &= mPc[7:0];
        if (flags[`ADL_FROM_DATA]) eAdl &= externalDBRead;
        if (flags[`ADL_PRESET_LSB +: 3] != 3'd0) begin
            eAdl &= adlPresetValue(flags[`ADL_PRESET_LSB +: 3]);
        end
        adhRaw = 8'hFF;
        if (flags[`ADH_FROM_PCH])  adhRaw &= mPc[15:8];
        if (flags[`ADH_FROM_DATA]) adhRaw &= externalDBRead;
        if (flags[`ADH_PRESET_LSB +: 2] != 2'd0) begin
            adhRaw &= adhPresetValue(flags[`ADH_PRESET_LSB +: 2]);
        end
        // Closed bridges join their buses into one wired AND
        merged = sbRaw;
        if (flags[`BRIDGE_SB_DB])  merged &= dbRaw;
        if (flags[`BRIDGE_SB_ADH]) merged &= adhRaw;
        eSb  = merged;
        eDb  = flags[`BRIDGE_SB_DB] ? merged : dbRaw;
        eAdh = flags[`BRIDGE_SB_ADH] ? merged : adhRaw;
        opA = flags[`ALU_A_ZERO] ? 8'h00 : eSb;
        case (flags[`ALU_B_LSB +: 2])
            2'd0: opB = eDb;
            2'd1: opB = ~eDb;
            2'd2: opB = eAdl;
            default: opB = 8'h00;
        endcase
        cin = flags[`CARRY_HIGH] | (flags[`CARRY_FROM_PSR] & mStatus[STATUS_C]);
        total = {1'b0, opA} + {1'b0, opB} + {8'h00, cin};
        op = aluOpT'(flags[`ALU_OP_LSB +: 3]);
        eResult = 8'h00;
        eCarry = 1'b0;
        eOverflow = 1'b0;
        case (op)
            aluAdd: begin
                eResult = total[7:0];
                eCarry = total[8];
                eOverflow = ~(opA[7] ^ opB[7]) & (opA[7] ^ eResult[7]);
            end
            aluAnd: eResult = opA & opB;
            aluOr:  eResult = opA | opB;
            aluEor: eResult = opA ^ opB;
            aluRor: begin
                eResult = {cin, opA[7:1]};
                eCarry = opA[0];
            end
            default: eResult = 8'h00;
        endcase
    endtask

    task automatic commitModel();
        statusT st;
        pcT     base;
        if (flags[`LOAD_X])   mX = eSb;
        if (flags[`LOAD_Y])   mY = eSb;
        if (flags[`LOAD_ACC]) mAcc = eSb;
        if (flags[`LOAD_SP])  mSp = eSb;
        if (flags[`LOAD_ABL]) mAbl = eAdl;
        if (flags[`LOAD_ABH]) mAbh = eAdh;
        if (flags[`LOAD_DOR]) mDor = eDb;
        if (flags[`LOAD_ALU]) mHold = eResult;
        base = flags[`LOAD_PC] ? {eAdh, eAdl} : mPc;
        mPc = base + {15'd0, flags[`PC_INC]};
        st = mStatus;
        if (flags[`PSR_FROM_DB]) begin
            st = {eDb[7:6], 2'b10, eDb[3:0]}; // B stays clear, bit 5 stays set
        end else begin
            if (flags[`Z_FROM_DB]) st[STATUS_Z] = (eDb == 8'h00);
            if (flags[`N_FROM_DB]) st[STATUS_N] = eDb[7];
            if (flags[`C_FROM_ALU]) begin
                st[STATUS_C] = eCarry;
            end else if (flags[`SET_C]) begin
                st[STATUS_C] = flags[`MANUAL_VALUE];
            end
            if (flags[`V_FROM_ALU]) st[STATUS_V] = eOverflow;
            if (flags[`SET_I]) st[STATUS_I] = flags[`MANUAL_VALUE];
            if (flags[`SET_D]) st[STATUS_D] = flags[`MANUAL_VALUE];
        end
        if (setOverflow) st[STATUS_V] = 1'b1;
        mStatus = st;
    endtask

    task automatic checkOutputs();
        compareByte("addressLow", mAbl, addressLow);
        compareByte("addressHigh", mAbh, addressHigh);
        compareByte("externalDBWrite", mDor, externalDBWrite);
        compareStatus("status", mStatus, status);
        compareBit("aluCarryOut", eCarry, aluCarryOut);
        compareBit("pclMSB", mPc[7], pclMSB);
    endtask

    // Entered 2 ns after a rising edge, returns at the same point one cycle later
    task automatic stepCycle(input flagsT f, input byteT data, input logic so);
        flags = f;
        externalDBRead = data;
        setOverflow = so;
        evaluateModel();
        @(negedge clk); // Inputs and buses settled here
        checkOutputs();
        commitModel();
        @(posedge clk);
        #2;
    endtask

    task automatic runTransfers();
        stepCycle(flagWord(`DB_FROM_DATA, `LOAD_DOR), 8'h5A, 1'b0);
        compareByte("externalDBWrite", 8'h5A, externalDBWrite);
        stepCycle(flagWord(`ADL_FROM_DATA, `ADH_FROM_DATA, `LOAD_ABL, `LOAD_ABH), 8'hC3, 1'b0);
        compareByte("addressLow", 8'hC3, addressLow);
        compareByte("addressHigh", 8'hC3, addressHigh);
        stepCycle(flagWord(`LOAD_DOR, `LOAD_ABL, `LOAD_ABH), 8'h00, 1'b0); // Nothing driven
        compareByte("externalDBWrite", 8'hFF, externalDBWrite);
        compareByte("addressLow", 8'hFF, addressLow);
        compareByte("addressHigh", 8'hFF, addressHigh);
        stepCycle(flagWord(`DB_FROM_DATA, `BRIDGE_SB_DB, `LOAD_X), 8'h3C, 1'b0);
        stepCycle(flagWord(`SB_FROM_X, `BRIDGE_SB_ADH, `LOAD_ABH), 8'h00, 1'b0);
        compareByte("addressHigh", 8'h3C, addressHigh);
        // X against the data byte on the merged SB/ADH
        stepCycle(flagWord(`SB_FROM_X, `BRIDGE_SB_ADH, `ADH_FROM_DATA, `LOAD_ABH), 8'hF0, 1'b0);
        compareByte("addressHigh", 8'h30, addressHigh);
        stepCycle(withField(flagWord(`ADL_FROM_DATA, `LOAD_ABL), `ADL_PRESET_LSB, 3, 3),
                  8'h0F, 1'b0);
        compareByte("addressLow", 8'h0C, addressLow);
    endtask

    task automatic runAluOps();
        aluOpT ops[7];
        byteT  operands[7];
        logic  carryHigh[7];
        logic  invertB[7];
        flagsT f;
        ops = '{aluAdd, aluAdd, aluAdd, aluAnd, aluOr, aluEor, aluRor};
        operands = '{8'h50, 8'hF0, 8'h3D, 8'hA5, 8'hA5, 8'hA5, 8'h00};
        carryHigh = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
        invertB = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}; // Third add is 3C - 3D
        for (int i = 0; i < 7; i++) begin
            // The previous result leaves on ADL while X op DB forms
            f = flagWord(`SB_FROM_X, `DB_FROM_DATA, `LOAD_ALU, `ADL_FROM_ALU, `LOAD_ABL,
                         `C_FROM_ALU);
            f[`V_FROM_ALU] = 1'b1;
            f[`CARRY_HIGH] = carryHigh[i];
            f = withField(f, `ALU_OP_LSB, 3, int'(ops[i]));
            f = withField(f, `ALU_B_LSB, 2, invertB[i] ? 1 : 0);
            stepCycle(f, operands[i], 1'b0);
            if (i == 1) compareByte("addressLow", 8'h8C, addressLow);
            if (i == 3) compareByte("addressLow", 8'hFF, addressLow);
        end
        stepCycle(flagWord(`ADL_FROM_ALU, `LOAD_ABL), 8'h00, 1'b0);
        compareByte("addressLow", 8'h9E, addressLow); // Carry rotated into bit 7
    endtask

    task automatic runStatusUpdates();
        stepCycle(flagWord(`DB_FROM_DATA, `PSR_FROM_DB), 8'hC3, 1'b0);
        compareStatus("status", 8'hE3, status);
        stepCycle(flagWord(`DB_FROM_DATA, `Z_FROM_DB, `N_FROM_DB), 8'h00, 1'b0);
        compareStatus("status", 8'h63, status);
        stepCycle(flagWord(`SET_C, `SET_I, `SET_D, `MANUAL_VALUE), 8'h00, 1'b0);
        compareStatus("status", 8'h6F, status);
        stepCycle(flagWord(`SET_C, `SET_I, `SET_D), 8'h00, 1'b0);
        compareStatus("status", 8'h62, status);
        // 00 + FF from the idle DB clears C and V
        stepCycle(withField(flagWord(`ALU_A_ZERO, `V_FROM_ALU, `C_FROM_ALU), `ALU_OP_LSB, 3,
                            aluAdd), 8'h00, 1'b0);
        compareStatus("status", 8'h22, status);
        stepCycle(flagWord(`Z_FROM_DB), 8'h00, 1'b1);
        compareStatus("status", 8'h60, status);
        stepCycle(flagWord(`DB_FROM_PSR, `BREAK_READ, `LOAD_DOR), 8'h00, 1'b0);
        compareByte("externalDBWrite", 8'h70, externalDBWrite);
    endtask

    task automatic runProgramCounter();
        stepCycle(withField(withField(flagWord(`LOAD_PC), `ADH_PRESET_LSB, 2, 2),
                            `ADL_PRESET_LSB, 3, 3), 8'h00, 1'b0);
        compareBit("pclMSB", 1'b1, pclMSB); // PC now 01FC
        repeat (4) stepCycle(flagWord(`PC_INC), 8'h00, 1'b0);
        compareBit("pclMSB", 1'b0, pclMSB);
        stepCycle(flagWord(`ADL_FROM_PCL, `ADH_FROM_PCH, `LOAD_ABL, `LOAD_ABH, `DB_FROM_PCH,
                           `LOAD_DOR), 8'h00, 1'b0);
        compareByte("addressLow", 8'h00, addressLow);
        compareByte("addressHigh", 8'h02, addressHigh);
        compareByte("externalDBWrite", 8'h02, externalDBWrite);
    endtask

    task automatic runRandom();
        logic [63:0] bits;
        flagsT       f;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            bits = randomBits(`NUMFLAGS);
            f = bits[`NUMFLAGS-1:0];
            bits = randomBits(9);
            stepCycle(f, bits[7:0], bits[8]);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flags = '0;
        externalDBRead = '0;
        setOverflow = 1'b0;
        lfsrState = 16'd76;
        resetModel();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        compareByte("addressLow", 8'h00, addressLow);
        compareByte("addressHigh", 8'h00, addressHigh);
        compareByte("externalDBWrite", 8'h00, externalDBWrite);
        compareBit("pclMSB", 1'b0, pclMSB);
        compareStatus("status", 8'h24, status);
        runTransfers();
        runAluOps();
        runStatusUpdates();
        runProgramCounter();
        runRandom();
        $display("Errors: byte %0d, status %0d, bit %0d", byteErrors, statusErrors, bitErrors);
        if (byteErrors + statusErrors + bitErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+verilog
verilog/dataTypesPkg.sv
verilog/aluStatusPkg.sv
verilog/internalBus.sv
verilog/busNetwork.sv
verilog/registerFile.sv
verilog/programCounter.sv
verilog/alu.sv
verilog/statusRegister.sv
verilog/internalDataflow.sv
test/tbInternalDataflow.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module tbInternalDataflow -o simv \
    && ./obj_dir/simv 2>&1 | tee sim.log \
    || echo "Build or simulation did not complete"
grep -q "Regression passed" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
